/* list.f */
+incdir+tb
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_bus_if.sv
rtl/rv_sequencer.sv
rtl/rv_core.sv
tb/tb_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - rtl/rv_pkg.sv
      - rtl/rv_decoder.sv
      - rtl/rv_regfile.sv
      - rtl/rv_alu.sv
      - rtl/rv_bus_if.sv
      - rtl/rv_sequencer.sv
      - rtl/rv_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_core.sv

/* tb/tb_model.svh */
// instruction-set model of the core, included inside tb_core
// run_model fills exp_q with every bus transfer the program should make
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
	logic              instr;
	logic [XLEN-1:0]   addr;
	logic [XLEN-1:0]   wdata;
	logic [STRB_W-1:0] strb;
} xfer_t;

xfer_t exp_q[$];
logic [XLEN-1:0] m_regs [0:31];
logic [XLEN-1:0] m_mem [0:MEM_WORDS-1];
logic [XLEN-1:0] m_pc;

function automatic logic [XLEN-1:0] lane_mask(logic [STRB_W-1:0] strb);
	logic [XLEN-1:0] m;
	for (int k = 0; k < STRB_W; k++)
		m[8*k +: 8] = {8{strb[k]}};
	return m;
endfunction

// one instruction, returns 1 when the core must trap on it
function automatic bit model_step();
	instr_u iw;
	logic [6:0] opc, f7;
	logic [2:0] f3;
	logic [XLEN-1:0] a, b, r, ea, data, nxt;
	logic [XLEN-1:0] immi, imms, immb, immu, immj;
	logic [STRB_W-1:0] strb;
	bit wr, taken;
	iw = m_mem[m_pc[11:2]];
	exp_q.push_back('{1'b1, m_pc, '0, '0}); // the fetch itself
	opc = iw.reg_view.opcode;
	f3 = iw.reg_view.funct3;
	f7 = iw.reg_view.funct7;
	a = m_regs[iw.reg_view.rs1];
	b = m_regs[iw.reg_view.rs2];
	immi = {{20{iw[31]}}, iw[31:20]};
	imms = {{20{iw[31]}}, iw.store_view.imm_hi, iw.store_view.imm_lo};
	immb = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
	immu = {iw[31:12], 12'b0};
	immj = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
	nxt = m_pc + 32'd4;
	wr = 1'b1;
	r = '0;
	case (opc)
		OPC_LUI:   r = immu;
		OPC_AUIPC: r = m_pc + immu;
		OPC_JAL, OPC_JALR: begin
			r = m_pc + 32'd4; // link
			nxt = (opc == OPC_JAL) ? m_pc + immj : (a + immi) & ~32'd1;
			if (nxt[1]) return 1'b1;
		end
		OPC_BRANCH: begin
			wr = 1'b0;
			case (f3)
				3'd0: taken = a == b;
				3'd1: taken = a != b;
				3'd4: taken = $signed(a) < $signed(b);
				3'd5: taken = $signed(a) >= $signed(b);
				3'd6: taken = a < b;
				default: taken = a >= b;
			endcase
			if (taken) nxt = m_pc + immb;
			if (nxt[1]) return 1'b1;
		end
		OPC_LOAD: begin
			ea = a + immi;
			if ((f3[1:0] == 2'd2 && ea[1:0] != 2'd0) || (f3[1:0] == 2'd1 && ea[0]))
				return 1'b1;
			exp_q.push_back('{1'b0, {ea[31:2], 2'b00}, '0, '0});
			data = m_mem[ea[11:2]] >> (8 * ea[1:0]);
			case (f3)
				3'd0: r = {{24{data[7]}}, data[7:0]};
				3'd1: r = {{16{data[15]}}, data[15:0]};
				3'd4: r = {24'b0, data[7:0]};
				3'd5: r = {16'b0, data[15:0]};
				default: r = data;
			endcase
		end
		OPC_STORE: begin
			wr = 1'b0;
			ea = a + imms;
			if ((f3[1:0] == 2'd2 && ea[1:0] != 2'd0) || (f3[1:0] == 2'd1 && ea[0]))
				return 1'b1;
			case (f3[1:0])
				2'd0: begin
					data = {4{b[7:0]}};
					strb = 4'b0001 << ea[1:0];
				end
				2'd1: begin
					data = {2{b[15:0]}};
					strb = 4'b0011 << ea[1:0];
				end
				default: begin
					data = b;
					strb = 4'hf;
				end
			endcase
			exp_q.push_back('{1'b0, {ea[31:2], 2'b00}, data, strb});
			for (int k = 0; k < STRB_W; k++)
				if (strb[k]) m_mem[ea[11:2]][8*k +: 8] = data[8*k +: 8];
		end
		OPC_OP_IMM, OPC_OP: begin
			if (opc == OPC_OP_IMM) b = immi;
			case (f3)
				3'd0: r = (opc == OPC_OP && f7[5]) ? a - b : a + b;
				3'd1: r = a << b[4:0];
				3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'd3: r = (a < b) ? 32'd1 : 32'd0;
				3'd4: r = a ^ b;
				3'd5: begin
					if (f7[5])
						r = $signed(a) >>> b[4:0];
					else
						r = a >> b[4:0];
				end
				3'd6: r = a | b;
				default: r = a & b;
			endcase
		end
		default: return 1'b1; // ecall, ebreak and unknown words
	endcase
	if (wr && iw.reg_view.rd != 5'd0) m_regs[iw.reg_view.rd] = r;
	m_pc = nxt;
	return 1'b0;
endfunction

task automatic run_model();
	m_pc = '0;
	exp_q.delete();
	for (int i = 0; i < 32; i++)
		m_regs[i] = '0;
	for (int n = 0; n < 4096; n++)
		if (model_step()) break;
endtask

`endif

/* tb/tb_core.sv */
// testbench for rv_core, random programs checked against an instruction-set model
// every DUT bus transfer is compared in order with the model's list
`timescale 1ns/1ps
`default_nettype none

module tb_core;
	import rv_pkg::*;

	localparam int MEM_WORDS = 1024; // program from 0, data from 0x600
	localparam int CYC_PER_INSTR = 20;
	localparam logic [XLEN-1:0] EBREAK_WORD = 32'h00100073;

	logic clk = 1'b0;
	logic resetn, mem_ready, mem_valid, mem_instr, trap;
	logic [XLEN-1:0] mem_rdata, mem_addr, mem_wdata;
	logic [STRB_W-1:0] mem_wstrb;
	logic [XLEN-1:0] mem [0:MEM_WORDS-1];
	logic [XLEN-1:0] prog[$];
	string test_name;
	bit max_delay, pending;
	int delay_left;

	`include "tb_model.svh"

	rv_core #(.PROGADDR_RESET(32'h0)) DUT (
		.clk, .resetn, .mem_ready, .mem_rdata, .mem_valid, .mem_instr,
		.mem_addr, .mem_wdata, .mem_wstrb, .trap
	);

	always #2 clk = ~clk;

	task automatic abort_run(string why);
		$display("%s, in test %s", why, test_name);
		$display("TB FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_word(string what, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
		if (exp !== act) begin
			$display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
			abort_run("value mismatch");
		end
	endtask

	task automatic check_strb(string what, logic [STRB_W-1:0] exp, logic [STRB_W-1:0] act);
		if (exp !== act) begin
			$display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
			abort_run("value mismatch");
		end
	endtask

	task automatic check_bit(string what, logic exp, logic act);
		if (exp !== act) begin
			$display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
			abort_run("value mismatch");
		end
	endtask

	// memory responder, ready after 0..3 wait cycles
	always @(posedge clk) begin
		#1;
		if (!mem_valid) begin
			mem_ready = 1'b0;
			pending = 1'b0;
		end else if (!pending) begin
			pending = 1'b1;
			delay_left = max_delay ? 3 : $urandom_range(0, 3);
		end else if (delay_left != 0) begin
			delay_left--;
		end
		if (pending && delay_left == 0) begin
			mem_ready = 1'b1;
			mem_rdata = mem[mem_addr[11:2]];
		end
	end

	// transfer completes at the next rising edge
	always @(negedge clk) begin : monitor
		xfer_t e;
		logic [XLEN-1:0] m;
		if (resetn && mem_valid && mem_ready) begin
			if (exp_q.size() == 0)
				abort_run("DUT made a bus transfer beyond the expected list");
			e = exp_q.pop_front();
			m = lane_mask(e.strb);
			check_bit("mem_instr", e.instr, mem_instr);
			check_word("mem_addr", e.addr, mem_addr);
			check_strb("mem_wstrb", e.strb, mem_wstrb);
			check_word("mem_wdata lanes", e.wdata & m, mem_wdata & m);
			for (int k = 0; k < STRB_W; k++)
				if (mem_wstrb[k]) mem[mem_addr[11:2]][8*k +: 8] = mem_wdata[8*k +: 8];
		end
	end

	function automatic logic [XLEN-1:0] enc_r(logic [6:0] f7, logic [4:0] rs2,
			logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [XLEN-1:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [XLEN-1:0] enc_s(logic [11:0] imm, logic [4:0] rs2,
			logic [4:0] rs1, logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [XLEN-1:0] enc_b(logic [12:0] imm, logic [4:0] rs2,
			logic [4:0] rs1, logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [XLEN-1:0] enc_u(logic [19:0] imm, logic [4:0] rd,
			logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [XLEN-1:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [4:0] rnd_reg(int lo, int hi);
		return 5'($urandom_range(lo, hi));
	endfunction

	task automatic add_li(int rd);
		prog.push_back(enc_u(20'($urandom), 5'(rd), OPC_LUI));
		prog.push_back(enc_i(12'($urandom), 5'(rd), 3'b000, 5'(rd), OPC_OP_IMM));
	endtask

	task automatic clear_memory();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = (i * 32'h9e3779b1) ^ (i << 20) ^ 32'h5a5a0000;
	endtask

	// loads prog, runs the model, resets the DUT and follows it into the trap
	task automatic run_program();
		int cycles;
		int limit;
		limit = prog.size() * CYC_PER_INSTR;
		for (int i = 0; i < prog.size(); i++)
			mem[i] = prog[i];
		m_mem = mem;
		run_model();
		@(posedge clk);
		#1 resetn = 1'b0;
		repeat (2) @(posedge clk);
		#1 resetn = 1'b1;
		cycles = 0;
		while (trap !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) abort_run("timeout, trap did not rise within the cycle limit");
		end
		if (exp_q.size() != 0) abort_run("trap rose before all expected bus transfers");
		repeat (20) begin
			@(negedge clk);
			check_bit("trap held", 1'b1, trap);
			check_bit("mem_valid after trap", 1'b0, mem_valid);
		end
	endtask

	task automatic test_alu();
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm;
		test_name = "alu";
		prog.delete();
		for (int n = 0; n < 40; n++) begin
			f3 = 3'($urandom_range(0, 7));
			imm = 12'($urandom);
			f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1)) ? 7'h20 : 7'h00;
			case ($urandom_range(0, 3))
				0: prog.push_back(enc_r(f7, rnd_reg(0, 15), rnd_reg(0, 15), f3, rnd_reg(1, 15)));
				1: begin
					if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = f7; // shift encodings
					prog.push_back(enc_i(imm, rnd_reg(0, 15), f3, rnd_reg(1, 15), OPC_OP_IMM));
				end
				2: prog.push_back(enc_u(20'($urandom), rnd_reg(1, 15), OPC_LUI));
				default: prog.push_back(enc_u(20'($urandom), rnd_reg(1, 15), OPC_AUIPC));
			endcase
		end
		for (int r = 1; r <= 15; r++)
			prog.push_back(enc_s(12'(12'h700 + 4 * r), 5'(r), 5'd0, 3'b010));
		prog.push_back(EBREAK_WORD);
		clear_memory();
		run_program();
	endtask

	task automatic test_stores();
		logic [11:0] addr;
		bit half;
		test_name = "subword_stores";
		prog.delete();
		for (int r = 1; r <= 8; r++)
			add_li(r);
		for (int n = 0; n < 24; n++) begin
			half = $urandom_range(0, 1);
			addr = 12'(12'h600 + $urandom_range(0, 511));
			if (half) addr[0] = 1'b0;
			prog.push_back(enc_s(addr, rnd_reg(1, 8), 5'd0, half ? 3'b001 : 3'b000));
		end
		prog.push_back(EBREAK_WORD);
		clear_memory();
		run_program();
	endtask

	task automatic test_loads();
		logic [11:0] addr;
		logic [2:0] f3;
		logic [4:0] rd;
		test_name = "loads";
		prog.delete();
		clear_memory();
		for (int i = 384; i < 448; i++)
			mem[i] = $urandom; // 0x600..0x6ff
		for (int n = 0; n < 24; n++) begin
			case ($urandom_range(0, 4))
				0: f3 = 3'd0;
				1: f3 = 3'd4;
				2: f3 = 3'd1;
				3: f3 = 3'd5;
				default: f3 = 3'd2;
			endcase
			addr = 12'(12'h600 + $urandom_range(0, 255));
			if (f3[1:0] == 2'd1) addr[0] = 1'b0;
			if (f3[1:0] == 2'd2) addr[1:0] = 2'b00;
			rd = rnd_reg(1, 15);
			prog.push_back(enc_i(addr, 5'd0, f3, rd, OPC_LOAD));
			prog.push_back(enc_s(12'(12'h700 + 4 * n), rd, 5'd0, 3'b010));
		end
		prog.push_back(EBREAK_WORD);
		run_program();
	endtask

	task automatic test_control();
		int skip;
		logic [2:0] f3;
		test_name = "control_flow";
		prog.delete();
		add_li(1);
		add_li(2);
		add_li(4);
		prog.push_back(enc_i(12'd0, 5'd1, 3'b000, 5'd3, OPC_OP_IMM)); // x3 equals x1
		for (int n = 0; n < 16; n++) begin
			skip = $urandom_range(1, 2);
			case ($urandom_range(0, 2))
				0: begin
					case ($urandom_range(0, 5))
						0: f3 = 3'd0;
						1: f3 = 3'd1;
						2: f3 = 3'd4;
						3: f3 = 3'd5;
						4: f3 = 3'd6;
						default: f3 = 3'd7;
					endcase
					prog.push_back(enc_b(13'(4 * (skip + 1)), rnd_reg(1, 4), rnd_reg(1, 4), f3));
				end
				1: prog.push_back(enc_j(21'(4 * (skip + 1)), rnd_reg(8, 12)));
				default: begin
					// jalr target relative to the auipc before it
					prog.push_back(enc_u(20'd0, 5'd5, OPC_AUIPC));
					prog.push_back(enc_i(12'(4 * (skip + 2)), 5'd5, 3'b000, rnd_reg(8, 12),
						OPC_JALR));
				end
			endcase
			repeat (skip)
				prog.push_back(enc_i(12'($urandom), rnd_reg(1, 12), 3'b000, rnd_reg(8, 12),
					OPC_OP_IMM));
		end
		for (int r = 5; r <= 12; r++)
			prog.push_back(enc_s(12'(12'h700 + 4 * r), 5'(r), 5'd0, 3'b010));
		prog.push_back(EBREAK_WORD);
		clear_memory();
		run_program();
	endtask

	task automatic test_traps();
		logic [XLEN-1:0] bad [3];
		string names [3];
		bad[0] = 32'hffffffff;
		bad[1] = EBREAK_WORD;
		bad[2] = enc_i(12'd2, 5'd0, 3'b010, 5'd1, OPC_LOAD); // lw from 0x2
		names[0] = "trap_illegal";
		names[1] = "trap_ebreak";
		names[2] = "trap_misaligned";
		for (int k = 0; k < 3; k++) begin
			test_name = names[k];
			prog.delete();
			prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
			prog.push_back(enc_i(12'd3, 5'd1, 3'b000, 5'd2, OPC_OP_IMM));
			prog.push_back(bad[k]);
			clear_memory();
			run_program();
		end
	endtask

	initial begin
		void'($urandom(32'h75ebaa41));
		resetn = 1'b0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		max_delay = 1'b0;
		pending = 1'b0;
		delay_left = 0;
		test_alu();
		// same program again, every transfer at the longest ready delay
		test_name = "back_pressure";
		max_delay = 1'b1;
		clear_memory();
		run_program();
		max_delay = 1'b0;
		test_stores();
		test_loads();
		test_control();
		test_traps();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
// top of the multi-cycle RV32I core, connects decoder, registers, ALU, bus and FSM
// PROGADDR_RESET sets the address of the first fetch
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
	parameter logic [31:0] PROGADDR_RESET = 32'h0
) (
	input  wire                          clk,
	input  wire                          resetn,
	input  wire                          mem_ready,
	input  wire [rv_pkg::XLEN-1:0]       mem_rdata,
	output logic                         mem_valid,
	output logic                         mem_instr,
	output logic [rv_pkg::XLEN-1:0]      mem_addr,
	output logic [rv_pkg::XLEN-1:0]      mem_wdata,
	output logic [rv_pkg::STRB_W-1:0]    mem_wstrb,
	output logic                         trap
);
	import rv_pkg::*;

	logic [REG_IDX_W-1:0] rs1, rs2, rd, rf_waddr;
	logic [XLEN-1:0] imm, rdata1, rdata2, rf_wdata;
	logic [XLEN-1:0] alu_a, alu_b, alu_result, addr, wdata, rdata_word;
	logic [ALU_OP_W-1:0] alu_op;
	logic [1:0] mem_size, size;
	logic op2_is_imm, is_lui, is_auipc, is_jal, is_jalr, is_branch, is_load, is_store;
	logic dec_unsigned, bus_unsigned, illegal, is_system;
	logic instr_load, alu_taken, rf_we, halt, mem_done;
	logic do_rinst, do_rdata, do_wdata;

	rv_decoder u_decoder (
		.clk, .resetn, .instr_load, .instr_word(mem_rdata),
		.rs1, .rs2, .rd, .imm, .alu_op, .op2_is_imm,
		.is_lui, .is_auipc, .is_jal, .is_jalr, .is_branch, .is_load, .is_store,
		.mem_size, .load_unsigned(dec_unsigned), .illegal, .is_system
	);

	rv_regfile u_regfile (
		.clk, .resetn, .raddr1(rs1), .raddr2(rs2),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata), .rdata1, .rdata2
	);

	rv_alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .taken(alu_taken));

	rv_bus_if u_bus (
		.clk, .resetn, .halt, .do_rinst, .do_rdata, .do_wdata, .addr, .wdata, .size,
		.load_unsigned(bus_unsigned), .mem_ready, .mem_rdata,
		.mem_valid, .mem_instr, .mem_addr, .mem_wdata, .mem_wstrb, .mem_done, .rdata_word
	);

	rv_sequencer #(.PROGADDR_RESET(PROGADDR_RESET)) u_seq (
		.clk, .resetn, .rd, .imm, .op2_is_imm,
		.is_lui, .is_auipc, .is_jal, .is_jalr, .is_branch, .is_load, .is_store,
		.mem_size, .ld_unsigned(dec_unsigned), .illegal, .is_system,
		.rdata1, .rdata2, .alu_result, .alu_taken, .mem_done, .rdata_word,
		.instr_load, .alu_a, .alu_b, .do_rinst, .do_rdata, .do_wdata,
		.addr, .wdata, .size, .load_unsigned(bus_unsigned), .halt,
		.rf_we, .rf_waddr, .rf_wdata, .trap
	);

endmodule

`default_nettype wire

/* rtl/rv_sequencer.sv */
// main control FSM, fetch / decode / exec / memory, with writeback and pc update
// writeback of the previous instruction happens in the first FETCH cycle
`timescale 1ns/1ps
`default_nettype none

module rv_sequencer #(
	parameter logic [31:0] PROGADDR_RESET = 32'h0
) (
	input  wire                            clk,
	input  wire                            resetn,
	input  wire [rv_pkg::REG_IDX_W-1:0]    rd,
	input  wire [rv_pkg::XLEN-1:0]         imm,
	input  wire                            op2_is_imm,
	input  wire                            is_lui,
	input  wire                            is_auipc,
	input  wire                            is_jal,
	input  wire                            is_jalr,
	input  wire                            is_branch,
	input  wire                            is_load,
	input  wire                            is_store,
	input  wire [1:0]                      mem_size,
	input  wire                            ld_unsigned,
	input  wire                            illegal,
	input  wire                            is_system,
	input  wire [rv_pkg::XLEN-1:0]         rdata1,
	input  wire [rv_pkg::XLEN-1:0]         rdata2,
	input  wire [rv_pkg::XLEN-1:0]         alu_result,
	input  wire                            alu_taken,
	input  wire                            mem_done,
	input  wire [rv_pkg::XLEN-1:0]         rdata_word,
	output logic                           instr_load,
	output logic [rv_pkg::XLEN-1:0]        alu_a,
	output logic [rv_pkg::XLEN-1:0]        alu_b,
	output logic                           do_rinst,
	output logic                           do_rdata,
	output logic                           do_wdata,
	output logic [rv_pkg::XLEN-1:0]        addr,
	output logic [rv_pkg::XLEN-1:0]        wdata,
	output logic [1:0]                     size,
	output logic                           load_unsigned,
	output logic                           halt,
	output logic                           rf_we,
	output logic [rv_pkg::REG_IDX_W-1:0]   rf_waddr,
	output logic [rv_pkg::XLEN-1:0]        rf_wdata,
	output logic                           trap
);
	import rv_pkg::*;

	localparam logic [5:0] ST_FETCH  = 6'b000001;
	localparam logic [5:0] ST_DECODE = 6'b000010;
	localparam logic [5:0] ST_EXEC   = 6'b000100;
	localparam logic [5:0] ST_LDMEM  = 6'b001000;
	localparam logic [5:0] ST_STMEM  = 6'b010000;
	localparam logic [5:0] ST_TRAP   = 6'b100000;

	logic [5:0] state;
	logic [XLEN-1:0] pc, op1, op2, sdata, daddr, wb_data;
	logic wb_pending;
	logic [XLEN-1:0] pc_plus4, br_target, jmp_target;
	logic data_misalign;

	assign pc_plus4 = pc + 32'd4;
	assign br_target = pc + imm;
	assign jmp_target = {alu_result[XLEN-1:1], 1'b0}; // jalr drops bit 0
	assign data_misalign = (mem_size == SIZE_WORD && alu_result[1:0] != 2'b00) ||
		(mem_size == SIZE_HALF && alu_result[0]);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_FETCH;
			pc <= PROGADDR_RESET;
			do_rinst <= 1'b1; // first fetch right out of reset
			do_rdata <= 1'b0;
			do_wdata <= 1'b0;
			wb_pending <= 1'b0;
		end else begin
			case (state)
				ST_FETCH: begin
					wb_pending <= 1'b0; // written this cycle
					if (mem_done) begin
						do_rinst <= 1'b0;
						state <= ST_DECODE;
					end
				end
				ST_DECODE: begin
					if (illegal || is_system) begin
						state <= ST_TRAP;
					end else begin
						op1 <= is_lui ? '0 : ((is_auipc || is_jal) ? pc : rdata1);
						op2 <= op2_is_imm ? imm : rdata2;
						sdata <= rdata2;
						state <= ST_EXEC;
					end
				end
				ST_EXEC: begin
					pc <= pc_plus4;
					if (is_branch) begin
						if (alu_taken && br_target[1]) begin
							state <= ST_TRAP;
						end else begin
							if (alu_taken)
								pc <= br_target;
							do_rinst <= 1'b1;
							state <= ST_FETCH;
						end
					end else if (is_jal || is_jalr) begin
						if (jmp_target[1]) begin
							state <= ST_TRAP;
						end else begin
							pc <= jmp_target;
							wb_data <= pc_plus4; // link
							wb_pending <= 1'b1;
							do_rinst <= 1'b1;
							state <= ST_FETCH;
						end
					end else if (is_load || is_store) begin
						if (data_misalign) begin
							state <= ST_TRAP;
						end else begin
							daddr <= alu_result;
							do_rdata <= is_load;
							do_wdata <= is_store;
							state <= is_load ? ST_LDMEM : ST_STMEM;
						end
					end else begin
						wb_data <= alu_result;
						wb_pending <= 1'b1;
						do_rinst <= 1'b1;
						state <= ST_FETCH;
					end
				end
				ST_LDMEM: if (mem_done) begin
					wb_data <= rdata_word;
					wb_pending <= 1'b1;
					do_rdata <= 1'b0;
					do_rinst <= 1'b1;
					state <= ST_FETCH;
				end
				ST_STMEM: if (mem_done) begin
					do_wdata <= 1'b0;
					do_rinst <= 1'b1;
					state <= ST_FETCH;
				end
				default: ; // trap, held until reset
			endcase
		end
	end

	assign instr_load = state == ST_FETCH && mem_done;
	assign alu_a = op1;
	assign alu_b = op2;
	assign addr = (state == ST_FETCH) ? pc : daddr;
	assign wdata = sdata;
	assign size = (state == ST_FETCH) ? SIZE_WORD : mem_size;
	assign load_unsigned = ld_unsigned;
	assign halt = state == ST_TRAP;
	assign trap = state == ST_TRAP;
	assign rf_we = state == ST_FETCH && wb_pending;
	assign rf_waddr = rd;
	assign rf_wdata = wb_data;

	a_state_onehot: assert property (@(posedge clk) disable iff (!resetn) $onehot(state));

endmodule

`default_nettype wire

/* rtl/rv_bus_if.sv */
// memory bus master, turns a held request level into one valid/ready transfer
// also places store lanes, builds strobes and extends load data
`timescale 1ns/1ps
`default_nettype none

module rv_bus_if (
	input  wire                          clk,
	input  wire                          resetn,
	input  wire                          halt,
	input  wire                          do_rinst,
	input  wire                          do_rdata,
	input  wire                          do_wdata,
	input  wire [rv_pkg::XLEN-1:0]       addr,
	input  wire [rv_pkg::XLEN-1:0]       wdata,
	input  wire [1:0]                    size,
	input  wire                          load_unsigned,
	input  wire                          mem_ready,
	input  wire [rv_pkg::XLEN-1:0]       mem_rdata,
	output logic                         mem_valid,
	output logic                         mem_instr,
	output logic [rv_pkg::XLEN-1:0]      mem_addr,
	output logic [rv_pkg::XLEN-1:0]      mem_wdata,
	output logic [rv_pkg::STRB_W-1:0]    mem_wstrb,
	output logic                         mem_done,
	output logic [rv_pkg::XLEN-1:0]      rdata_word
);
	import rv_pkg::*;

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_READ  = 2'd1;
	localparam logic [1:0] ST_WRITE = 2'd2;

	logic [1:0] state;
	logic [XLEN-1:0] lane_wdata;
	logic [STRB_W-1:0] lane_strb;
	logic [7:0] rd_byte;
	logic [15:0] rd_half;

	always_comb begin
		case (size)
			SIZE_HALF: begin
				lane_wdata = {2{wdata[15:0]}};
				lane_strb = addr[1] ? 4'b1100 : 4'b0011;
			end
			SIZE_BYTE: begin
				lane_wdata = {4{wdata[7:0]}};
				lane_strb = 4'b0001 << addr[1:0];
			end
			default: begin
				lane_wdata = wdata;
				lane_strb = '1;
			end
		endcase
	end

	assign rd_byte = mem_rdata[8*addr[1:0] +: 8];
	assign rd_half = mem_rdata[16*addr[1] +: 16];

	always_comb begin
		case (size)
			SIZE_HALF: rdata_word = {{16{rd_half[15] && !load_unsigned}}, rd_half};
			SIZE_BYTE: rdata_word = {{24{rd_byte[7] && !load_unsigned}}, rd_byte};
			default:   rdata_word = mem_rdata;
		endcase
	end

	assign mem_done = mem_valid && mem_ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
			mem_valid <= 1'b0;
			mem_wstrb <= '0;
		end else begin
			case (state)
				ST_IDLE: if (!halt && (do_rinst || do_rdata || do_wdata)) begin
					mem_valid <= 1'b1;
					mem_instr <= do_rinst;
					mem_addr <= {addr[XLEN-1:2], 2'b00}; // word aligned
					mem_wdata <= lane_wdata;
					mem_wstrb <= do_wdata ? lane_strb : '0;
					state <= do_wdata ? ST_WRITE : ST_READ;
				end
				ST_READ, ST_WRITE: if (mem_ready) begin
					mem_valid <= 1'b0;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_bus_hold: assert property (@(posedge clk) disable iff (!resetn)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr));

endmodule

`default_nettype wire

/* rtl/rv_alu.sv */
// single cycle ALU with barrel shifter and branch compare
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
	input  wire [rv_pkg::ALU_OP_W-1:0]  op,
	input  wire [rv_pkg::XLEN-1:0]      a,
	input  wire [rv_pkg::XLEN-1:0]      b,
	output logic [rv_pkg::XLEN-1:0]     result,
	output logic                        taken
);
	import rv_pkg::*;

	logic [XLEN-1:0] add_sub, shl, shr;
	logic eq, lts, ltu;

	assign add_sub = (op == ALU_SUB) ? a - b : a + b;
	assign eq = a == b;
	assign lts = $signed(a) < $signed(b);
	assign ltu = a < b;
	assign shl = a << b[4:0];
	// 33 bit arithmetic shift, top bit chooses sra vs srl fill
	assign shr = XLEN'($signed({op == ALU_SRA && a[XLEN-1], a}) >>> b[4:0]);

	always_comb begin
		case (op)
			ALU_ADD, ALU_SUB: result = add_sub;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, lts};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, ltu};
			ALU_XOR:  result = a ^ b;
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			ALU_SLL:  result = shl;
			ALU_SRL, ALU_SRA: result = shr;
			default:  result = add_sub; // branch ops ignore it
		endcase
	end

	always_comb begin
		case (op)
			ALU_BEQ:  taken = eq;
			ALU_BNE:  taken = !eq;
			ALU_BLT:  taken = lts;
			ALU_BGE:  taken = !lts;
			ALU_BLTU: taken = ltu;
			ALU_BGEU: taken = !ltu;
			default:  taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
// general purpose registers x1..x31, x0 is hardwired to zero
// two async read ports, one write port on the clock edge
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  wire                            clk,
	input  wire                            resetn,
	input  wire [rv_pkg::REG_IDX_W-1:0]    raddr1,
	input  wire [rv_pkg::REG_IDX_W-1:0]    raddr2,
	input  wire                            we,
	input  wire [rv_pkg::REG_IDX_W-1:0]    waddr,
	input  wire [rv_pkg::XLEN-1:0]         wdata,
	output logic [rv_pkg::XLEN-1:0]        rdata1,
	output logic [rv_pkg::XLEN-1:0]        rdata2
);
	import rv_pkg::*;

	localparam int NREGS = 2 ** REG_IDX_W;

	logic [XLEN-1:0] regs [1:NREGS-1];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 1; i < NREGS; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	// a write aimed at x0 leaves the register seen on port 1 unchanged
	a_x0_zero: assert property (@(posedge clk) disable iff (!resetn)
		we && waddr == '0 |=> raddr1 != $past(raddr1) || rdata1 == $past(rdata1));

endmodule

`default_nettype wire

/* rtl/rv_decoder.sv */
// instruction decoder, loads the fetched word and holds the decoded fields
// outputs stay valid until the next fetch capture
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  wire                            clk,
	input  wire                            resetn,
	input  wire                            instr_load,
	input  wire [rv_pkg::XLEN-1:0]         instr_word,
	output logic [rv_pkg::REG_IDX_W-1:0]   rs1,
	output logic [rv_pkg::REG_IDX_W-1:0]   rs2,
	output logic [rv_pkg::REG_IDX_W-1:0]   rd,
	output logic [rv_pkg::XLEN-1:0]        imm,
	output logic [rv_pkg::ALU_OP_W-1:0]    alu_op,
	output logic                           op2_is_imm,
	output logic                           is_lui,
	output logic                           is_auipc,
	output logic                           is_jal,
	output logic                           is_jalr,
	output logic                           is_branch,
	output logic                           is_load,
	output logic                           is_store,
	output logic [1:0]                     mem_size,
	output logic                           load_unsigned,
	output logic                           illegal,
	output logic                           is_system
);
	import rv_pkg::*;

	instr_u ins;
	logic [6:0] opc, f7;
	logic [2:0] f3;
	logic [XLEN-1:0] imm_d;
	logic [ALU_OP_W-1:0] alu_op_d;
	logic sys_d, illegal_d;

	assign ins = instr_word;
	assign opc = ins.reg_view.opcode;
	assign f7 = ins.reg_view.funct7;
	assign f3 = ins.reg_view.funct3;

	// ecall / ebreak only, imm[0] picks which
	assign sys_d = opc == OPC_SYSTEM && f3 == 3'b000 && ins.reg_view.rs1 == '0 &&
		ins.reg_view.rd == '0 && {f7, ins.reg_view.rs2[4:1]} == '0;

	always_comb begin
		case (opc)
			OPC_LUI, OPC_AUIPC:
				imm_d = {f7, ins.reg_view.rs2, ins.reg_view.rs1, f3, 12'b0};
			OPC_JAL:
				imm_d = {{12{f7[6]}}, ins.reg_view.rs1, f3, ins.reg_view.rs2[0],
					f7[5:0], ins.reg_view.rs2[4:1], 1'b0};
			OPC_BRANCH:
				imm_d = {{20{f7[6]}}, ins.reg_view.rd[0], f7[5:0], ins.reg_view.rd[4:1], 1'b0};
			OPC_STORE:
				imm_d = {{20{ins.store_view.imm_hi[6]}}, ins.store_view.imm_hi,
					ins.store_view.imm_lo};
			default:
				imm_d = {{20{f7[6]}}, f7, ins.reg_view.rs2}; // I-type
		endcase
	end

	always_comb begin
		alu_op_d = ALU_ADD; // address and link sums
		if (opc == OPC_OP || opc == OPC_OP_IMM) begin
			case (f3)
				3'd0: alu_op_d = (opc == OPC_OP && f7[5]) ? ALU_SUB : ALU_ADD;
				3'd1: alu_op_d = ALU_SLL;
				3'd2: alu_op_d = ALU_SLT;
				3'd3: alu_op_d = ALU_SLTU;
				3'd4: alu_op_d = ALU_XOR;
				3'd5: alu_op_d = f7[5] ? ALU_SRA : ALU_SRL;
				3'd6: alu_op_d = ALU_OR;
				default: alu_op_d = ALU_AND;
			endcase
		end else if (opc == OPC_BRANCH) begin
			case (f3)
				3'd0: alu_op_d = ALU_BEQ;
				3'd1: alu_op_d = ALU_BNE;
				3'd4: alu_op_d = ALU_BLT;
				3'd5: alu_op_d = ALU_BGE;
				3'd6: alu_op_d = ALU_BLTU;
				default: alu_op_d = ALU_BGEU;
			endcase
		end
	end

	always_comb begin
		case (opc)
			OPC_LUI, OPC_AUIPC, OPC_JAL: illegal_d = 1'b0;
			OPC_JALR:   illegal_d = f3 != 3'b000;
			OPC_BRANCH: illegal_d = f3[2:1] == 2'b01;
			OPC_LOAD:   illegal_d = f3 == 3'b011 || f3[2:1] == 2'b11;
			OPC_STORE:  illegal_d = f3[2] || f3[1:0] == 2'b11;
			OPC_OP_IMM: illegal_d = (f3 == 3'd1 && f7 != '0) ||
				(f3 == 3'd5 && f7 != '0 && f7 != 7'h20);
			OPC_OP:     illegal_d = f7 != '0 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			OPC_SYSTEM: illegal_d = !sys_d;
			default:    illegal_d = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			{is_lui, is_auipc, is_jal, is_jalr} <= '0;
			{is_branch, is_load, is_store, illegal, is_system} <= '0;
		end else if (instr_load) begin
			is_lui    <= opc == OPC_LUI;
			is_auipc  <= opc == OPC_AUIPC;
			is_jal    <= opc == OPC_JAL;
			is_jalr   <= opc == OPC_JALR;
			is_branch <= opc == OPC_BRANCH;
			is_load   <= opc == OPC_LOAD;
			is_store  <= opc == OPC_STORE;
			illegal   <= illegal_d;
			is_system <= sys_d;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_load) begin
			rs1 <= ins.reg_view.rs1;
			rs2 <= ins.reg_view.rs2;
			rd <= ins.reg_view.rd;
			imm <= imm_d;
			alu_op <= alu_op_d;
			op2_is_imm <= !(opc == OPC_OP || opc == OPC_BRANCH);
			mem_size <= f3[1] ? SIZE_WORD : (f3[0] ? SIZE_HALF : SIZE_BYTE);
			load_unsigned <= f3[2];
		end
	end

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
// widths, opcodes, ALU operation codes and the instruction word views of the core
// imported by every core module and by the testbench
`default_nettype none

package rv_pkg;

	localparam int XLEN      = 32;
	localparam int STRB_W    = 4;
	localparam int REG_IDX_W = 5;
	localparam int ALU_OP_W  = 4;

	// major opcodes of the RV32I subset
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd9;
	localparam logic [ALU_OP_W-1:0] ALU_BEQ  = 4'd10; // branch compares
	localparam logic [ALU_OP_W-1:0] ALU_BNE  = 4'd11;
	localparam logic [ALU_OP_W-1:0] ALU_BLT  = 4'd12;
	localparam logic [ALU_OP_W-1:0] ALU_BGE  = 4'd13;
	localparam logic [ALU_OP_W-1:0] ALU_BLTU = 4'd14;
	localparam logic [ALU_OP_W-1:0] ALU_BGEU = 4'd15;

	// access sizes, same coding as the bus word size
	localparam logic [1:0] SIZE_WORD = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_BYTE = 2'd2;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} reg_view_t;

	// S-type splits its immediate around rs1/rs2
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} store_view_t;

	typedef union packed {
		reg_view_t   reg_view;
		store_view_t store_view;
	} instr_u;

endpackage

`default_nettype wire
